/* rtl/camif_pkg.sv */
// shared widths and bus layouts, assuming a 10-bit sensor and a 16-bit host word
package camif_pkg;

   // ********************
   // widths
   localparam int PIX_W  = 10;
   localparam int WORD_W = 16;

   // one truncated pixel in paired mode
   localparam int HALF_W = WORD_W / 2;

   // ********************
   // interrupt thresholds, in words
   localparam int unsigned BURST_SMALL = 16;
   localparam int unsigned BURST_LARGE = 64;

   // fixed low byte of the status word
   localparam logic [7:0] STATUS_ID = 8'h05;

   // ********************
   // control word bit positions
   localparam int CTRL_RGB_BIT   = 15;
   localparam int CTRL_EN_BIT    = 12;
   localparam int CTRL_BURST_BIT = 11;

   // ********************
   // sensor bus, 12 bits
   typedef struct packed {
      logic             frame_valid;
      logic             line_valid;
      logic [PIX_W-1:0] data;
   } pix_bus_t;

   // host strobe interface, 19 bits
   // wr and rd are single-cycle strobes, sel_fifo picks the pixel port
   typedef struct packed {
      logic              wr;
      logic              rd;
      logic              sel_fifo;
      logic [WORD_W-1:0] wdata;
   } host_req_t;

   // control register, 3 bits
   typedef struct packed {
      logic rgb_mode;
      logic capture_en;
      logic big_burst;
   } ctrl_t;

endpackage

/* rtl/pixel_packer.sv */
// capture arms only on a rising frame_valid seen while enabled; a frame already running is skipped
`timescale 1ns/1ps

module pixel_packer
   import camif_pkg::*;
(
   input  logic              pinclk,
   input  logic              rst,
   input  pix_bus_t          i_pix,
   input  ctrl_t             i_ctrl,
   output logic              o_word_valid,
   output logic [WORD_W-1:0] o_word
);

   pix_bus_t          pix_q;
   logic              fv_d;
   logic              frame_rise;
   logic              armed;
   logic              arm_next;
   logic              pix_valid;
   logic [PIX_W-1:0]  pix_data;
   logic              pair_phase;
   logic [HALF_W-1:0] first_hi;

   // ********************
   // stage 1, sensor sampling
   always_ff @(posedge pinclk or posedge rst)
   begin
      if (rst)
      begin
         pix_q <= '0;
         fv_d  <= 1'b0;
      end
      else
      begin
         pix_q <= i_pix;
         fv_d  <= pix_q.frame_valid;
      end
   end

   assign frame_rise = pix_q.frame_valid & ~fv_d;

   // dropping capture_en disarms at once
   assign arm_next = i_ctrl.capture_en & (armed | frame_rise);

   // ********************
   // stage 2, pixel qualify
   always_ff @(posedge pinclk or posedge rst)
   begin
      if (rst)
      begin
         armed     <= 1'b0;
         pix_valid <= 1'b0;
      end
      else
      begin
         armed     <= arm_next;
         pix_valid <= pix_q.frame_valid & pix_q.line_valid & arm_next;
      end
   end

   always_ff @(posedge pinclk)
   begin
      pix_data <= pix_q.data;
   end

   // ********************
   // stage 3, word packing
   always_ff @(posedge pinclk or posedge rst)
   begin
      if (rst)
      begin
         pair_phase   <= 1'b0;
         o_word_valid <= 1'b0;
      end
      else
      begin
         // paired mode emits on the second pixel of each pair
         o_word_valid <= pix_valid & (~i_ctrl.rgb_mode | pair_phase);
         if (!i_ctrl.capture_en || !i_ctrl.rgb_mode)
            pair_phase <= 1'b0;
         else if (pix_valid)
            pair_phase <= ~pair_phase;
      end
   end

   always_ff @(posedge pinclk)
   begin
      if (pix_valid && !pair_phase)
         first_hi <= pix_data[PIX_W-1 -: HALF_W];
      // first pixel of the pair lands in the upper byte
      if (i_ctrl.rgb_mode)
         o_word <= {first_hi, pix_data[PIX_W-1 -: HALF_W]};
      else
         o_word <= {{(WORD_W-PIX_W){1'b0}}, pix_data};
   end

endmodule

/* rtl/host_regs.sv */
// writes with sel_fifo high are ignored; read strobes pass through the same cycle
`timescale 1ns/1ps

module host_regs
   import camif_pkg::*;
(
   input  logic      pinclk,
   input  logic      rst,
   input  host_req_t i_host,
   output ctrl_t     o_ctrl,
   output logic      o_fifo_rd,
   output logic      o_status_rd
);

   ctrl_t ctrl_q;
   logic  ctrl_wr;

   // ********************
   // control register
   assign ctrl_wr = i_host.wr & ~i_host.sel_fifo;

   always_ff @(posedge pinclk or posedge rst)
   begin
      if (rst)
      begin
         ctrl_q <= '0;
      end
      else if (ctrl_wr)
      begin
         ctrl_q.rgb_mode   <= i_host.wdata[CTRL_RGB_BIT];
         ctrl_q.capture_en <= i_host.wdata[CTRL_EN_BIT];
         ctrl_q.big_burst  <= i_host.wdata[CTRL_BURST_BIT];
      end
   end

   assign o_ctrl = ctrl_q;

   // ********************
   // read strobe decode
   // kept combinational so read data lands one cycle after the strobe
   assign o_fifo_rd   = i_host.rd & i_host.sel_fifo;
   assign o_status_rd = i_host.rd & ~i_host.sel_fifo;

endmodule

/* rtl/frame_fifo.sv */
// DEPTH must be a power of two; o_data is show-ahead and the caller gates push by full and pop by empty
`timescale 1ns/1ps

module frame_fifo
   import camif_pkg::*;
#(
   parameter int DEPTH = 512
) (
   input  logic                    pinclk,
   input  logic                    rst,
   input  logic                    i_flush,
   input  logic                    i_push,
   input  logic                    i_pop,
   input  logic [WORD_W-1:0]       i_data,
   output logic [WORD_W-1:0]       o_data,
   output logic                    o_empty,
   output logic                    o_full,
   output logic [$clog2(DEPTH):0]  o_level
);

   localparam int AW = $clog2(DEPTH);
   localparam int LW = AW + 1;

   logic [WORD_W-1:0] mem [DEPTH];
   logic [AW-1:0]     wr_ptr;
   logic [AW-1:0]     rd_ptr;
   logic [LW-1:0]     level;

   // ********************
   // storage
   always_ff @(posedge pinclk)
   begin
      if (i_push)
         mem[wr_ptr] <= i_data;
   end

   assign o_data = mem[rd_ptr];

   // ********************
   // pointers and fill level
   always_ff @(posedge pinclk or posedge rst)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level  <= '0;
      end
      else if (i_flush)
      begin
         // flush wins over any push or pop in the same cycle
         wr_ptr <= '0;
         rd_ptr <= '0;
         level  <= '0;
      end
      else
      begin
         if (i_push)
            wr_ptr <= wr_ptr + AW'(1);
         if (i_pop)
            rd_ptr <= rd_ptr + AW'(1);
         if (i_push && !i_pop)
            level <= level + LW'(1);
         else if (!i_push && i_pop)
            level <= level - LW'(1);
      end
   end

   assign o_empty = (level == '0);
   assign o_full  = (level == LW'(DEPTH));
   assign o_level = level;

endmodule

/* rtl/camif_readout.sv */
// capture_en low holds the FIFO flushed; an empty FIFO read returns 0 and overflow clears on status read
`timescale 1ns/1ps

module camif_readout
   import camif_pkg::*;
#(
   parameter int FIFO_DEPTH = 512
) (
   input  logic              pinclk,
   input  logic              rst,
   input  ctrl_t             i_ctrl,
   input  logic              i_word_valid,
   input  logic [WORD_W-1:0] i_word,
   input  logic              i_fifo_rd,
   input  logic              i_status_rd,
   output logic [WORD_W-1:0] o_host_rdata,
   output logic              o_intr
);

   localparam int LW = $clog2(FIFO_DEPTH) + 1;

   logic              fifo_flush;
   logic              fifo_push;
   logic              fifo_pop;
   logic              fifo_empty;
   logic              fifo_full;
   logic [WORD_W-1:0] fifo_data;
   logic [LW-1:0]     fifo_level;
   logic [WORD_W-1:0] status_word;
   logic              overflow;
   int unsigned       burst_size;
   logic              intr_next;

   // ********************
   // FIFO traffic
   assign fifo_flush = ~i_ctrl.capture_en;
   assign fifo_push  = i_word_valid & ~fifo_full;
   assign fifo_pop   = i_fifo_rd & ~fifo_empty;

   frame_fifo #(
      .DEPTH   (FIFO_DEPTH)
   ) frame_fifo_i (
      .pinclk  (pinclk),
      .rst     (rst),
      .i_flush (fifo_flush),
      .i_push  (fifo_push),
      .i_pop   (fifo_pop),
      .i_data  (i_word),
      .o_data  (fifo_data),
      .o_empty (fifo_empty),
      .o_full  (fifo_full),
      .o_level (fifo_level)
   );

   // sticky, a status read clears it even if a word is lost that cycle
   always_ff @(posedge pinclk or posedge rst)
   begin
      if (rst)
         overflow <= 1'b0;
      else if (i_status_rd)
         overflow <= 1'b0;
      else if (i_word_valid && fifo_full)
         overflow <= 1'b1;
   end

   // ********************
   // host read data
   assign status_word = {i_ctrl.rgb_mode, 2'b00, i_ctrl.capture_en, i_ctrl.big_burst,
                         overflow, 1'b0, fifo_empty, STATUS_ID};

   always_ff @(posedge pinclk or posedge rst)
   begin
      if (rst)
         o_host_rdata <= '0;
      else if (i_fifo_rd)
         o_host_rdata <= fifo_empty ? '0 : fifo_data;
      else if (i_status_rd)
         o_host_rdata <= status_word;
   end

   // ********************
   // burst interrupt
   assign burst_size = i_ctrl.big_burst ? BURST_LARGE : BURST_SMALL;

   // drops together with the level on a flush
   assign intr_next = ~fifo_flush & (32'(fifo_level) >= burst_size);

   always_ff @(posedge pinclk or posedge rst)
   begin
      if (rst)
         o_intr <= 1'b0;
      else
         o_intr <= intr_next;
   end

endmodule

/* rtl/camif_top.sv */
// single clock design; all inputs are sampled on pinclk and host strobes must be one cycle wide
`timescale 1ns/1ps

module camif_top
   import camif_pkg::*;
#(
   parameter int FIFO_DEPTH = 512
) (
   input  logic              pinclk,
   input  logic              rst,
   input  pix_bus_t          i_pix,
   input  host_req_t         i_host,
   output logic [WORD_W-1:0] o_host_rdata,
   output logic              o_intr
);

   ctrl_t             ctrl;
   logic              word_valid;
   logic [WORD_W-1:0] word;
   logic              fifo_rd;
   logic              status_rd;

   pixel_packer pixel_packer_i (
      .pinclk       (pinclk),
      .rst          (rst),
      .i_pix        (i_pix),
      .i_ctrl       (ctrl),
      .o_word_valid (word_valid),
      .o_word       (word)
   );

   host_regs host_regs_i (
      .pinclk      (pinclk),
      .rst         (rst),
      .i_host      (i_host),
      .o_ctrl      (ctrl),
      .o_fifo_rd   (fifo_rd),
      .o_status_rd (status_rd)
   );

   camif_readout #(
      .FIFO_DEPTH   (FIFO_DEPTH)
   ) camif_readout_i (
      .pinclk       (pinclk),
      .rst          (rst),
      .i_ctrl       (ctrl),
      .i_word_valid (word_valid),
      .i_word       (word),
      .i_fifo_rd    (fifo_rd),
      .i_status_rd  (status_rd),
      .o_host_rdata (o_host_rdata),
      .o_intr       (o_intr)
   );

endmodule

/* sim/camif_props.sv */
// bound into camif_readout by name; every check is disabled while rst is high
`timescale 1ns/1ps

module camif_props
(
   input logic pinclk,
   input logic rst,
   input logic o_intr,
   input logic fifo_empty,
   input logic fifo_full,
   input logic fifo_pop,
   input logic fifo_flush,
   input logic i_status_rd,
   input logic overflow
);

   // ********************
   // interrupt and FIFO
   intr_low_when_empty: assert property (@(posedge pinclk) disable iff (rst)
      fifo_empty |-> !o_intr)
   else
      $error("o_intr is high while the FIFO is empty");

   // a full FIFO with no pop or flush stays full, so no word slips in
   no_push_when_full: assert property (@(posedge pinclk) disable iff (rst)
      fifo_full && !fifo_pop && !fifo_flush |=> fifo_full)
   else
      $error("the FIFO took a word while full");

   // sticky flag clears on the status read
   status_read_clears_ovf: assert property (@(posedge pinclk) disable iff (rst)
      i_status_rd |=> !overflow)
   else
      $error("overflow still set after a status read");

endmodule

bind camif_readout camif_props camif_props_i (
   .pinclk      (pinclk),
   .rst         (rst),
   .o_intr      (o_intr),
   .fifo_empty  (fifo_empty),
   .fifo_full   (fifo_full),
   .fifo_pop    (fifo_pop),
   .fifo_flush  (fifo_flush),
   .i_status_rd (i_status_rd),
   .overflow    (overflow)
);

/* sim/camif_tb.sv */
// FIFO_DEPTH is 32 here; expected words follow the packing rules over an LCG pixel stream with seed 46
`timescale 1ns/1ps

module camif_tb
   import camif_pkg::*;
();

   localparam int          DEPTH      = 32;
   localparam int          INTR_SMALL = 16;
   localparam int          INTR_LARGE = 64;
   localparam logic [7:0]  ID_BYTE    = 8'h05;
   localparam logic [15:0] EN_MASK    = 16'h1000;
   localparam int          NROWS      = 7;

   localparam int MODE_NORMAL = 0;
   localparam int MODE_LATE   = 1;
   localparam int MODE_INTR   = 2;
   localparam int MODE_FLUSH  = 3;

   // each table row holds the control word, frame shape, scenario, reads and status bits 15:8
   typedef struct packed {
      logic [15:0] ctrl;
      int          ppl;
      int          lines;
      int          mode;
      int          nread;
      logic [7:0]  status_hi;
   } stim_t;

   logic              pinclk = 1'b0;
   logic              rst;
   pix_bus_t          i_pix;
   host_req_t         i_host;
   logic [WORD_W-1:0] o_host_rdata;
   logic              o_intr;

   logic [31:0]       lcg_state = 32'd46;
   logic [15:0]       cur_ctrl;
   logic              have_first;
   logic [PIX_W-1:0]  first_px;
   logic [15:0]       exp_q [$];
   time               last_pix_time = 0;
   time               intr_rise_time = 0;
   logic              intr_seen = 1'b0;
   int                err_cnt = 0;
   int                check_cnt = 0;

   camif_top #(
      .FIFO_DEPTH   (DEPTH)
   ) camif_top_i (
      .pinclk       (pinclk),
      .rst          (rst),
      .i_pix        (i_pix),
      .i_host       (i_host),
      .o_host_rdata (o_host_rdata),
      .o_intr       (o_intr)
   );

   always #2 pinclk = ~pinclk;

   // time of the latest rising o_intr
   always @(negedge pinclk)
   begin
      if (o_intr && !intr_seen)
         intr_rise_time = $time;
      intr_seen = o_intr;
   end

   // ********************
   // stimulus table
   function automatic stim_t stim_row(input int idx);
      stim_t s;
      case (idx)
         0:       s = '{16'h1000, 6, 2, MODE_LATE, 14, 8'h10};
         1:       s = '{16'h9000, 8, 2, MODE_NORMAL, 8, 8'h90};
         2:       s = '{16'h1000, 16, 1, MODE_INTR, 16, 8'h10};
         3:       s = '{16'h1000, 10, 4, MODE_NORMAL, 32, 8'h14};
         4:       s = '{16'h1000, 5, 2, MODE_FLUSH, 10, 8'h10};
         5:       s = '{16'h1800, 10, 2, MODE_NORMAL, 20, 8'h18};
         default: s = '{16'h9000, 12, 2, MODE_NORMAL, 6, 8'h90};
      endcase
      return s;
   endfunction

   function automatic int total_cycles();
      stim_t s;
      int    sum;
      int    frames;
      sum = 100;
      for (int i = 0; i < NROWS; i++)
      begin
         s = stim_row(i);
         frames = (s.mode == MODE_FLUSH) ? 3 : ((s.mode == MODE_LATE) ? 2 : 1);
         sum += frames * (6 + s.lines * (s.ppl + 3)) + s.nread * 5 + 60;
      end
      return sum;
   endfunction

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // ********************
   // reference model
   task automatic note_ctrl(input logic [15:0] word);
      cur_ctrl = word;
      if (!word[12] || !word[15])
         have_first = 1'b0;
      // capture off empties the FIFO
      if (!word[12])
         exp_q.delete();
   endtask

   task automatic expect_pixel(input logic [PIX_W-1:0] px);
      logic [15:0] w;
      if (cur_ctrl[15])
      begin
         if (!have_first)
         begin
            first_px = px;
            have_first = 1'b1;
            return;
         end
         w = {first_px[9:2], px[9:2]};
         have_first = 1'b0;
      end
      else
         w = {6'b000000, px};
      // words past the FIFO depth are lost
      if (exp_q.size() < DEPTH)
         exp_q.push_back(w);
   endtask

   function automatic logic [7:0] model_status_hi();
      return {cur_ctrl[15], 2'b00, cur_ctrl[12], cur_ctrl[11], 2'b00, (exp_q.size() == 0)};
   endfunction

   // ********************
   // checks
   task automatic compare_value(input string what, input logic [15:0] got,
                                input logic [15:0] exp);
      check_cnt++;
      assert (got === exp)
      else
      begin
         $display("ERR %0t: %s read 0x%04h, expected 0x%04h", $time, what, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_intr(input string what);
      int   burst;
      logic exp_intr;
      burst = cur_ctrl[11] ? INTR_LARGE : INTR_SMALL;
      exp_intr = (exp_q.size() >= burst);
      check_cnt++;
      assert (o_intr === exp_intr)
      else
      begin
         $display("ERR %0t: %s is %b, expected %b", $time, what, o_intr, exp_intr);
         err_cnt++;
      end
   endtask

   // ********************
   // host and sensor drivers
   task automatic host_write(input logic [15:0] word);
      @(posedge pinclk);
      i_host <= '{wr: 1'b1, rd: 1'b0, sel_fifo: 1'b0, wdata: word};
      note_ctrl(word);
      @(posedge pinclk);
      i_host <= '0;
   endtask

   task automatic host_read(input logic sel, output logic [15:0] data);
      @(posedge pinclk);
      i_host <= '{wr: 1'b0, rd: 1'b1, sel_fifo: sel, wdata: 16'h0000};
      @(posedge pinclk);
      i_host <= '0;
      @(negedge pinclk);
      data = o_host_rdata;
   endtask

   task automatic check_status(input string what, input logic [7:0] exp_hi);
      logic [15:0] rd;
      host_read(1'b0, rd);
      compare_value(what, rd, {exp_hi, ID_BYTE});
   endtask

   // a control write in the front porch lands while frame_valid is already high
   task automatic drive_frame(input int ppl, input int lines, input bit capture,
                              input bit mid_wr, input logic [15:0] mid_word);
      logic [PIX_W-1:0] px;
      for (int c = 0; c < 4; c++)
      begin
         @(posedge pinclk);
         i_pix <= '{frame_valid: 1'b1, line_valid: 1'b0, data: '0};
         if (mid_wr && c == 2)
         begin
            i_host <= '{wr: 1'b1, rd: 1'b0, sel_fifo: 1'b0, wdata: mid_word};
            note_ctrl(mid_word);
         end
         else
            i_host <= '0;
      end
      for (int l = 0; l < lines; l++)
      begin
         for (int k = 0; k < ppl; k++)
         begin
            @(posedge pinclk);
            lcg_state = lcg_next(lcg_state);
            px = lcg_state[25:16];
            i_pix <= '{frame_valid: 1'b1, line_valid: 1'b1, data: px};
            if (capture)
               expect_pixel(px);
            last_pix_time = $time;
         end
         repeat (3)
         begin
            @(posedge pinclk);
            i_pix <= '{frame_valid: 1'b1, line_valid: 1'b0, data: '0};
         end
      end
      repeat (2)
      begin
         @(posedge pinclk);
         i_pix <= '0;
      end
   endtask

   // packer stages, FIFO write and the interrupt register
   task automatic settle();
      repeat (6) @(posedge pinclk);
      @(negedge pinclk);
   endtask

   // ********************
   // one table row
   task automatic run_row(input int idx, input stim_t s);
      logic [15:0] rd;
      logic [15:0] exp_w;
      time         dt;
      int          cycles;
      host_write(16'h0000);
      if (s.mode == MODE_FLUSH)
      begin
         host_write(s.ctrl);
         drive_frame(s.ppl, s.lines, 1'b1, 1'b0, 16'h0000);
         settle();
         host_write(s.ctrl & ~EN_MASK);
         check_status($sformatf("row %0d status after flush", idx),
                      {s.ctrl[15], 2'b00, 1'b0, s.ctrl[11], 3'b001});
      end
      if (s.mode == MODE_LATE || s.mode == MODE_FLUSH)
         drive_frame(s.ppl, s.lines, 1'b0, 1'b1, s.ctrl);
      else
         host_write(s.ctrl);
      drive_frame(s.ppl, s.lines, 1'b1, 1'b0, 16'h0000);
      settle();
      if (s.mode == MODE_INTR)
      begin
         // 16th word is stored 4 cycles after its pixel is driven
         dt = intr_rise_time - last_pix_time;
         cycles = (intr_rise_time > last_pix_time) ? int'(dt) / 4 : -1;
         check_cnt++;
         assert (cycles >= 4 && cycles <= 6)
         else
         begin
            $display("ERR %0t: row %0d o_intr rose %0d cycles after the last pixel",
                     $time, idx, cycles);
            err_cnt++;
         end
      end
      check_intr($sformatf("row %0d o_intr after capture", idx));
      check_status($sformatf("row %0d status after capture", idx), s.status_hi);
      for (int i = 0; i < s.nread; i++)
      begin
         host_read(1'b1, rd);
         exp_w = (exp_q.size() > 0) ? exp_q.pop_front() : 16'h0000;
         compare_value($sformatf("row %0d word %0d", idx, i), rd, exp_w);
         @(negedge pinclk);
         check_intr($sformatf("row %0d o_intr after read %0d", idx, i));
      end
      check_status($sformatf("row %0d status after read back", idx), model_status_hi());
   endtask

   // ********************
   // main sequence
   initial
   begin : main_seq
      logic [15:0] rd;
      rst <= 1'b1;
      i_pix <= '0;
      i_host <= '0;
      cur_ctrl = 16'h0000;
      have_first = 1'b0;
      repeat (5) @(posedge pinclk);
      rst <= 1'b0;
      @(negedge pinclk);
      check_intr("o_intr after reset");
      host_read(1'b0, rd);
      compare_value("status after reset", rd, {8'h01, ID_BYTE});
      for (int r = 0; r < NROWS; r++)
         run_row(r, stim_row(r));
      $display("checks %0d errors %0d", check_cnt, err_cnt);
      if (err_cnt == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

   initial
   begin
      #(total_cycles() * 4 + 2000);
      $display("timeout: the run did not finish within its time limit");
      $display("test failed");
      $finish;
   end

endmodule

/* verilog.f */
rtl/camif_pkg.sv
rtl/pixel_packer.sv
rtl/host_regs.sv
rtl/frame_fifo.sv
rtl/camif_readout.sv
rtl/camif_top.sv
sim/camif_props.sv
sim/camif_tb.sv

/* run_sim.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module camif_tb -f verilog.f -o camif_sim \
   && ./obj_dir/camif_sim > sim.log 2>&1 \
   || echo "build or simulation stopped with an error" >> sim.log
cat sim.log
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0
